/* hw/rvDatapath_settings.svh */
/*
 * RV32I datapath settings
 * Widths, reset PC, bubble instruction and selector field widths
 */
`ifndef RV_DATAPATH_SETTINGS_SVH
`define RV_DATAPATH_SETTINGS_SVH

`define RV_XLEN         32
`define RV_REG_ADDR_W   5
`define RV_NUM_REGS     32
`define RV_RESET_PC     32'h0000_0000

// addi x0, x0, 0
`define RV_NOP_INSTR    32'h0000_0013

// Selector field widths
`define RV_IMM_SRC_W    3
`define RV_FWD_SEL_W    2
`define RV_ALU_OP_W     3
`define RV_RESULT_SEL_W 2

`endif

/* hw/rvDatapathPkg.sv */
/*
 * RV32I datapath package
 * Selector encodings and the payloads carried between pipeline stages
 */
`default_nettype none

`include "rvDatapath_settings.svh"

package rvDatapathPkg;

    typedef logic [`RV_XLEN-1:0]       dataT;
    typedef logic [`RV_REG_ADDR_W-1:0] regAddrT;

    typedef enum logic [`RV_IMM_SRC_W-1:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immSrcT;

    typedef enum logic [`RV_FWD_SEL_W-1:0] {
        fromRegFile   = 2'd0,
        fromWriteback = 2'd1,
        fromMemory    = 2'd2
    } forwardSelT;

    typedef enum logic {
        srcBReg = 1'b0,
        srcBImm = 1'b1
    } aluSrcT;

    typedef enum logic [`RV_ALU_OP_W-1:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd5
    } aluOpT;

    typedef enum logic [`RV_RESULT_SEL_W-1:0] {
        resultAlu     = 2'd0,
        resultMem     = 2'd1,
        resultPcPlus4 = 2'd2,
        resultImm     = 2'd3
    } resultSelT;

    // Fetch to decode
    typedef struct packed {
        dataT instr;
        dataT pc;
        dataT pcPlus4;
    } decodeStageT;

    // Decode to execute
    typedef struct packed {
        dataT    rd1;
        dataT    rd2;
        dataT    pc;
        dataT    pcPlus4;
        dataT    imm;
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
    } executeStageT;

    // Execute to memory
    typedef struct packed {
        dataT    aluResult;
        dataT    writeData;
        dataT    imm;
        dataT    pcPlus4;
        regAddrT rd;
    } memoryStageT;

    // Memory to writeback
    typedef struct packed {
        dataT    aluResult;
        dataT    readData;
        dataT    imm;
        dataT    pcPlus4;
        regAddrT rd;
    } writebackStageT;

endpackage

`default_nettype wire

/* hw/pipeStageReg.sv */
/*
 * Pipeline stage register
 * Holds one stage payload, with flush to a given clear value and stall
 */
`default_nettype none

module pipeStageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic stall_i,
    input  wire logic flush_i,
    input  payloadT   clearValue_i,
    input  payloadT   d_i,
    output payloadT   q_o
);

    // Flush wins over stall
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            q_o <= clearValue_i;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* hw/immExtend.sv */
/*
 * Immediate extender
 * Rebuilds the sign-extended I, S, B, J or U immediate of the decode instruction
 */
`default_nettype none

module immExtend
    import rvDatapathPkg::*;
(
    input  dataT   instr_i,
    input  immSrcT immSrc_i,
    output dataT   imm_o
);

    always_comb begin
        case (immSrc_i)
            immI: begin
                imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            immS: begin
                imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            // Branch offsets are halfword aligned
            immB: begin
                imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            immJ: begin
                imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            // Upper 20 bits, low bits zero
            immU: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/regFile.sv */
/*
 * Integer register file
 * Two read ports and one write port, x0 fixed at zero, write data bypassed to reads
 */
`default_nettype none

`include "rvDatapath_settings.svh"

module regFile
    import rvDatapathPkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  regAddrT   rs1_i,
    input  regAddrT   rs2_i,
    input  regAddrT   rd_i,
    input  wire logic we_i,
    input  dataT      wd_i,
    output dataT      rd1_o,
    output dataT      rd2_o
);

    dataT regs [`RV_NUM_REGS];
    logic writeLive;

    // x0 is never written
    assign writeLive = we_i && (rd_i != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[rd_i] <= wd_i;
        end
    end

    // Same-cycle write is seen by decode
    assign rd1_o = (writeLive && rs1_i == rd_i) ? wd_i : regs[rs1_i];
    assign rd2_o = (writeLive && rs2_i == rd_i) ? wd_i : regs[rs2_i];

endmodule

`default_nettype wire

/* hw/aluUnit.sv */
/*
 * ALU
 * add, sub, and, or and signed set-less-than, plus a zero flag for branches
 */
`default_nettype none

module aluUnit
    import rvDatapathPkg::*;
(
    input  dataT       a_i,
    input  dataT       b_i,
    input  aluOpT      op_i,
    output dataT       result_o,
    output logic       zero_o
);

    always_comb begin
        case (op_i)
            aluAdd: begin
                result_o = a_i + b_i;
            end
            aluSub: begin
                result_o = a_i - b_i;
            end
            aluAnd: begin
                result_o = a_i & b_i;
            end
            aluOr: begin
                result_o = a_i | b_i;
            end
            // Signed compare
            aluSlt: begin
                result_o = ($signed(a_i) < $signed(b_i)) ? dataT'(1) : '0;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

    // beq taken when sub gives zero
    assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

/* hw/executeStage.sv */
/*
 * Execute stage
 * Operand forwarding, ALU source select, ALU and branch target adder
 */
`default_nettype none

module executeStage
    import rvDatapathPkg::*;
(
    input  executeStageT stage_i,
    input  forwardSelT   forwardA_i,
    input  forwardSelT   forwardB_i,
    input  aluSrcT       aluSrc_i,
    input  aluOpT        aluOp_i,
    input  dataT         forwardM_i,
    input  dataT         resultW_i,
    output dataT         aluResult_o,
    output dataT         writeData_o,
    output dataT         pcTarget_o,
    output logic         zero_o
);

    dataT srcA;
    dataT srcBForwarded;
    dataT srcB;

    // Operand A: register value or a newer result still in flight
    always_comb begin
        case (forwardA_i)
            fromMemory: begin
                srcA = forwardM_i;
            end
            fromWriteback: begin
                srcA = resultW_i;
            end
            default: begin
                srcA = stage_i.rd1;
            end
        endcase
    end

    always_comb begin
        case (forwardB_i)
            fromMemory: begin
                srcBForwarded = forwardM_i;
            end
            fromWriteback: begin
                srcBForwarded = resultW_i;
            end
            default: begin
                srcBForwarded = stage_i.rd2;
            end
        endcase
    end

    assign srcB = (aluSrc_i == srcBImm) ? stage_i.imm : srcBForwarded;

    // Store data is the forwarded rs2 value
    assign writeData_o = srcBForwarded;

    aluUnit alu (
        .a_i      (srcA),
        .b_i      (srcB),
        .op_i     (aluOp_i),
        .result_o (aluResult_o),
        .zero_o   (zero_o)
    );

    assign pcTarget_o = stage_i.pc + stage_i.imm;

endmodule

`default_nettype wire

/* hw/rvDatapath.sv */
/*
 * RV32I five-stage datapath
 * Fetch PC, stage registers, register file and result selects, all steered by an external controller
 */
`default_nettype none

`include "rvDatapath_settings.svh"

module rvDatapath
    import rvDatapathPkg::*;
(
    input  wire logic clk,
    input  wire logic reset,

    input  dataT       instrF_i,
    input  dataT       readDataM_i,

    // Controller
    input  immSrcT     immSrcD_i,
    input  aluSrcT     aluSrcE_i,
    input  aluOpT      aluOpE_i,
    input  forwardSelT forwardAE_i,
    input  forwardSelT forwardBE_i,
    input  resultSelT  resultSelM_i,
    input  resultSelT  resultSelW_i,
    input  wire logic  regWriteW_i,
    input  wire logic  stallF_i,
    input  wire logic  stallD_i,
    input  wire logic  flushD_i,
    input  wire logic  flushE_i,
    input  wire logic  pcSrcE_i,

    output dataT       pcF_o,
    output logic [6:0] opD_o,
    output logic [2:0] funct3D_o,
    output logic       funct7b5D_o,
    output regAddrT    rs1D_o,
    output regAddrT    rs2D_o,
    output regAddrT    rdD_o,
    output regAddrT    rs1E_o,
    output regAddrT    rs2E_o,
    output regAddrT    rdE_o,
    output logic       zeroE_o,
    output dataT       aluResultM_o,
    output dataT       writeDataM_o,
    output regAddrT    rdM_o,
    output regAddrT    rdW_o
);

    dataT           pcPlus4F;
    dataT           pcTargetE;
    dataT           rd1D;
    dataT           rd2D;
    dataT           immD;
    dataT           aluResultE;
    dataT           writeDataE;
    dataT           forwardDataM;
    dataT           resultW;

    decodeStageT    decodeD;
    decodeStageT    decodeQ;
    decodeStageT    decodeClear;
    executeStageT   executeD;
    executeStageT   executeQ;
    memoryStageT    memoryD;
    memoryStageT    memoryQ;
    writebackStageT writebackD;
    writebackStageT writebackQ;

    // Fetch
    assign pcPlus4F = pcF_o + dataT'(4);

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= `RV_RESET_PC;
        end else if (!stallF_i) begin
            pcF_o <= pcSrcE_i ? pcTargetE : pcPlus4F;
        end
    end

    assign decodeD = '{instr: instrF_i, pc: pcF_o, pcPlus4: pcPlus4F};

    // A flushed decode slot holds a real NOP
    assign decodeClear = '{instr: `RV_NOP_INSTR, pc: '0, pcPlus4: '0};

    pipeStageReg #(.payloadT(decodeStageT)) decodeReg (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stallD_i),
        .flush_i      (flushD_i),
        .clearValue_i (decodeClear),
        .d_i          (decodeD),
        .q_o          (decodeQ)
    );

    // Decode
    assign opD_o       = decodeQ.instr[6:0];
    assign funct3D_o   = decodeQ.instr[14:12];
    assign funct7b5D_o = decodeQ.instr[30];
    assign rs1D_o      = decodeQ.instr[19:15];
    assign rs2D_o      = decodeQ.instr[24:20];
    assign rdD_o       = decodeQ.instr[11:7];

    immExtend immGen (
        .instr_i  (decodeQ.instr),
        .immSrc_i (immSrcD_i),
        .imm_o    (immD)
    );

    regFile rf (
        .clk   (clk),
        .reset (reset),
        .rs1_i (rs1D_o),
        .rs2_i (rs2D_o),
        .rd_i  (rdW_o),
        .we_i  (regWriteW_i),
        .wd_i  (resultW),
        .rd1_o (rd1D),
        .rd2_o (rd2D)
    );

    assign executeD = '{rd1: rd1D, rd2: rd2D, pc: decodeQ.pc, pcPlus4: decodeQ.pcPlus4,
                        imm: immD, rs1: rs1D_o, rs2: rs2D_o, rd: rdD_o};

    pipeStageReg #(.payloadT(executeStageT)) executeReg (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (1'b0),
        .flush_i      (flushE_i),
        .clearValue_i ('0),
        .d_i          (executeD),
        .q_o          (executeQ)
    );

    // Execute
    assign rs1E_o = executeQ.rs1;
    assign rs2E_o = executeQ.rs2;
    assign rdE_o  = executeQ.rd;

    executeStage exStage (
        .stage_i     (executeQ),
        .forwardA_i  (forwardAE_i),
        .forwardB_i  (forwardBE_i),
        .aluSrc_i    (aluSrcE_i),
        .aluOp_i     (aluOpE_i),
        .forwardM_i  (forwardDataM),
        .resultW_i   (resultW),
        .aluResult_o (aluResultE),
        .writeData_o (writeDataE),
        .pcTarget_o  (pcTargetE),
        .zero_o      (zeroE_o)
    );

    assign memoryD = '{aluResult: aluResultE, writeData: writeDataE, imm: executeQ.imm,
                       pcPlus4: executeQ.pcPlus4, rd: executeQ.rd};

    pipeStageReg #(.payloadT(memoryStageT)) memoryReg (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (1'b0),
        .flush_i      (1'b0),
        .clearValue_i ('0),
        .d_i          (memoryD),
        .q_o          (memoryQ)
    );

    // Memory
    assign aluResultM_o = memoryQ.aluResult;
    assign writeDataM_o = memoryQ.writeData;
    assign rdM_o        = memoryQ.rd;

    // Load data is not ready yet, so it cannot be forwarded from here
    always_comb begin
        case (resultSelM_i)
            resultPcPlus4: begin
                forwardDataM = memoryQ.pcPlus4;
            end
            resultImm: begin
                forwardDataM = memoryQ.imm;
            end
            default: begin
                forwardDataM = memoryQ.aluResult;
            end
        endcase
    end

    assign writebackD = '{aluResult: memoryQ.aluResult, readData: readDataM_i,
                          imm: memoryQ.imm, pcPlus4: memoryQ.pcPlus4, rd: memoryQ.rd};

    pipeStageReg #(.payloadT(writebackStageT)) writebackReg (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (1'b0),
        .flush_i      (1'b0),
        .clearValue_i ('0),
        .d_i          (writebackD),
        .q_o          (writebackQ)
    );

    // Writeback
    assign rdW_o = writebackQ.rd;

    always_comb begin
        case (resultSelW_i)
            resultMem: begin
                resultW = writebackQ.readData;
            end
            resultPcPlus4: begin
                resultW = writebackQ.pcPlus4;
            end
            resultImm: begin
                resultW = writebackQ.imm;
            end
            default: begin
                resultW = writebackQ.aluResult;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verif/rvDatapathTbClock.sv */
/*
 * Testbench clock and reset
 * Free-running clock of period 10, reset held high for the first 10 cycles
 */
`default_nettype none

module rvDatapathTbClock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* verif/rvDatapath_properties.sv */
/*
 * Datapath assertions
 * Reset PC, PC hold under fetch stall and execute flush, bound into the datapath
 */
`default_nettype none

`include "rvDatapath_settings.svh"

module rvDatapathProperties
    import rvDatapathPkg::*;
(
    input wire logic clk,
    input wire logic reset,
    input dataT      pcF_o,
    input wire logic stallF_i,
    input wire logic pcSrcE_i,
    input wire logic flushE_i,
    input regAddrT   rdE_o
);

    resetPc: assert property (@(posedge clk) reset |=> (pcF_o == `RV_RESET_PC))
        else $error("PC is not the reset PC after reset");

    // Redirect overrides nothing while fetch is stalled, but keep it out of the check
    stallHoldsPc: assert property (@(posedge clk) disable iff (reset)
        (stallF_i && !pcSrcE_i) |=> $stable(pcF_o))
        else $error("PC moved during a fetch stall");

    flushClearsExecute: assert property (@(posedge clk) disable iff (reset)
        flushE_i |=> (rdE_o == '0))
        else $error("Execute rd not cleared after flush");

endmodule

bind rvDatapath rvDatapathProperties props (
    .clk      (clk),
    .reset    (reset),
    .pcF_o    (pcF_o),
    .stallF_i (stallF_i),
    .pcSrcE_i (pcSrcE_i),
    .flushE_i (flushE_i),
    .rdE_o    (rdE_o)
);

`default_nettype wire

/* verif/rvDatapathTb.sv */
/*
 * Datapath testbench
 * Replays the per-cycle stimulus file into the DUT and checks the observed outputs
 */
`default_nettype none

`include "rvDatapath_settings.svh"

module rvDatapathTb
    import rvDatapathPkg::*;
();

    localparam int numCols  = 19;
    localparam int maxLines = 256;
    localparam string stimPath = "verif/rvDatapath_stimulus.txt";

    // Column positions within one stimulus line
    localparam int colInstr    = 0;
    localparam int colReadData = 1;
    localparam int colImmSrc   = 2;
    localparam int colAluSrc   = 3;
    localparam int colAluOp    = 4;
    localparam int colFwdA     = 5;
    localparam int colFwdB     = 6;
    localparam int colSelM     = 7;
    localparam int colSelW     = 8;
    localparam int colFlags    = 9;
    localparam int colMask     = 10;
    localparam int colPc       = 11;
    localparam int colOp       = 12;
    localparam int colRdE      = 13;
    localparam int colZero     = 14;
    localparam int colAluM     = 15;
    localparam int colWdM      = 16;
    localparam int colRdW      = 17;
    localparam int colGroup    = 18;

    // RV32I base instruction fields, used to predict the decode outputs
    typedef struct packed {
        logic [6:0] funct7;
        regAddrT    rs2;
        regAddrT    rs1;
        logic [2:0] funct3;
        regAddrT    rd;
        logic [6:0] opcode;
    } instrFieldsT;

    logic clk;
    logic reset;

    dataT       instrF;
    dataT       readDataM;
    immSrcT     immSrcD;
    aluSrcT     aluSrcE;
    aluOpT      aluOpE;
    forwardSelT forwardAE;
    forwardSelT forwardBE;
    resultSelT  resultSelM;
    resultSelT  resultSelW;
    logic       regWriteW;
    logic       stallF;
    logic       stallD;
    logic       flushD;
    logic       flushE;
    logic       pcSrcE;

    dataT       pcF;
    dataT       aluResultM;
    dataT       writeDataM;
    logic [6:0] opD;
    logic [2:0] funct3D;
    logic       funct7b5D;
    logic       zeroE;
    regAddrT    rs1D;
    regAddrT    rs2D;
    regAddrT    rdD;
    regAddrT    rs1E;
    regAddrT    rs2E;
    regAddrT    rdE;
    regAddrT    rdM;
    regAddrT    rdW;

    // Expected stage contents, stepped once per applied line
    instrFieldsT decodeExp;
    regAddrT     rs1ExpE;
    regAddrT     rs2ExpE;
    regAddrT     rdExpE;
    regAddrT     rdExpM;

    logic [31:0] stim [0:numCols*maxLines-1];
    int lineCount = 0;
    int errorCount = 0;
    int checkCount = 0;
    int groupChecks = 0;
    int groupErrors = 0;
    int currentGroup = 0;

    rvDatapathTbClock clockGen (.clk(clk), .reset(reset));

    rvDatapath DUT (
        .clk          (clk),
        .reset        (reset),
        .instrF_i     (instrF),
        .readDataM_i  (readDataM),
        .immSrcD_i    (immSrcD),
        .aluSrcE_i    (aluSrcE),
        .aluOpE_i     (aluOpE),
        .forwardAE_i  (forwardAE),
        .forwardBE_i  (forwardBE),
        .resultSelM_i (resultSelM),
        .resultSelW_i (resultSelW),
        .regWriteW_i  (regWriteW),
        .stallF_i     (stallF),
        .stallD_i     (stallD),
        .flushD_i     (flushD),
        .flushE_i     (flushE),
        .pcSrcE_i     (pcSrcE),
        .pcF_o        (pcF),
        .opD_o        (opD),
        .funct3D_o    (funct3D),
        .funct7b5D_o  (funct7b5D),
        .rs1D_o       (rs1D),
        .rs2D_o       (rs2D),
        .rdD_o        (rdD),
        .rs1E_o       (rs1E),
        .rs2E_o       (rs2E),
        .rdE_o        (rdE),
        .zeroE_o      (zeroE),
        .aluResultM_o (aluResultM),
        .writeDataM_o (writeDataM),
        .rdM_o        (rdM),
        .rdW_o        (rdW)
    );

    task automatic checkData(input string name, input dataT expected, input dataT actual);
        checkCount++;
        groupChecks++;
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            errorCount++;
            groupErrors++;
        end
    endtask

    task automatic checkReg(input string name, input regAddrT expected, input regAddrT actual);
        checkCount++;
        groupChecks++;
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            errorCount++;
            groupErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input bit expected, input bit actual);
        checkCount++;
        groupChecks++;
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
            errorCount++;
            groupErrors++;
        end
    endtask

    task automatic reportGroup();
        $display("group %0d done: %0d checks, %0d errors", currentGroup, groupChecks, groupErrors);
        groupChecks = 0;
        groupErrors = 0;
    endtask

    task automatic loadStimulus();
        int fd;
        fd = $fopen(stimPath, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open stimulus file %s", stimPath);
        end else begin
            $fclose(fd);
            $readmemh(stimPath, stim);
            while (lineCount < maxLines && !$isunknown(stim[lineCount*numCols])) begin
                lineCount++;
            end
        end
    endtask

    task automatic applyLine(input int lineIdx);
        int base;
        logic [31:0] flags;
        base = lineIdx * numCols;
        flags = stim[base + colFlags];
        instrF     <= stim[base + colInstr];
        readDataM  <= stim[base + colReadData];
        immSrcD    <= immSrcT'(stim[base + colImmSrc][2:0]);
        aluSrcE    <= aluSrcT'(stim[base + colAluSrc][0]);
        aluOpE     <= aluOpT'(stim[base + colAluOp][2:0]);
        forwardAE  <= forwardSelT'(stim[base + colFwdA][1:0]);
        forwardBE  <= forwardSelT'(stim[base + colFwdB][1:0]);
        resultSelM <= resultSelT'(stim[base + colSelM][1:0]);
        resultSelW <= resultSelT'(stim[base + colSelW][1:0]);
        regWriteW  <= flags[5];
        stallF     <= flags[4];
        stallD     <= flags[3];
        flushD     <= flags[2];
        flushE     <= flags[1];
        pcSrcE     <= flags[0];
    endtask

    // Stage contents after the next edge, following the stall and flush rules
    task automatic advanceModel(input int lineIdx);
        int base;
        logic [31:0] flags;
        base = lineIdx * numCols;
        flags = stim[base + colFlags];
        rdExpM = rdExpE;
        if (flags[1]) begin
            rs1ExpE = '0;
            rs2ExpE = '0;
            rdExpE  = '0;
        end else begin
            rs1ExpE = decodeExp.rs1;
            rs2ExpE = decodeExp.rs2;
            rdExpE  = decodeExp.rd;
        end
        if (flags[2]) begin
            decodeExp = instrFieldsT'(`RV_NOP_INSTR);
        end else if (!flags[3]) begin
            decodeExp = instrFieldsT'(stim[base + colInstr]);
        end
    endtask

    task automatic checkLine(input int lineIdx);
        int base;
        logic [31:0] mask;
        base = lineIdx * numCols;
        mask = stim[base + colMask];
        if (currentGroup != 0 && stim[base + colGroup] != currentGroup) begin
            reportGroup();
        end
        currentGroup = stim[base + colGroup];
        if (mask[0]) checkData("pcF_o", stim[base + colPc], pcF);
        if (mask[1]) checkData("opD_o", stim[base + colOp], dataT'(opD));
        if (mask[2]) checkReg("rdE_o", regAddrT'(stim[base + colRdE]), rdE);
        if (mask[3]) checkFlag("zeroE_o", stim[base + colZero][0], zeroE);
        if (mask[4]) checkData("aluResultM_o", stim[base + colAluM], aluResultM);
        if (mask[5]) checkData("writeDataM_o", stim[base + colWdM], writeDataM);
        if (mask[6]) checkReg("rdW_o", regAddrT'(stim[base + colRdW]), rdW);
        checkData("funct3D_o", dataT'(decodeExp.funct3), dataT'(funct3D));
        checkFlag("funct7b5D_o", decodeExp.funct7[5], funct7b5D);
        checkReg("rs1D_o", decodeExp.rs1, rs1D);
        checkReg("rs2D_o", decodeExp.rs2, rs2D);
        checkReg("rdD_o", decodeExp.rd, rdD);
        checkReg("rs1E_o", rs1ExpE, rs1E);
        checkReg("rs2E_o", rs2ExpE, rs2E);
        checkReg("rdM_o", rdExpM, rdM);
    endtask

    initial begin : mainFlow
        instrF     = `RV_NOP_INSTR;
        readDataM  = '0;
        immSrcD    = immI;
        aluSrcE    = srcBReg;
        aluOpE     = aluAdd;
        forwardAE  = fromRegFile;
        forwardBE  = fromRegFile;
        resultSelM = resultAlu;
        resultSelW = resultAlu;
        regWriteW  = 1'b0;
        stallF     = 1'b0;
        stallD     = 1'b0;
        flushD     = 1'b0;
        flushE     = 1'b0;
        pcSrcE     = 1'b0;
        // Reset leaves a NOP in decode and empty later stages
        decodeExp  = instrFieldsT'(`RV_NOP_INSTR);
        rs1ExpE    = '0;
        rs2ExpE    = '0;
        rdExpE     = '0;
        rdExpM     = '0;
        loadStimulus();
        if (lineCount == 0) begin
            $display("ERROR: no stimulus lines could be read from %s", stimPath);
            $display("Test failed");
            $finish;
        end else begin
            // First line goes in at the edge that releases reset
            @(negedge reset);
            for (int i = 0; i < lineCount; i++) begin
                if (i > 0) begin
                    @(posedge clk);
                end
                applyLine(i);
                @(negedge clk);
                checkLine(i);
                advanceModel(i);
            end
            reportGroup();
            $display("summary: %0d lines, %0d checks, %0d errors",
                     lineCount, checkCount, errorCount);
            if (errorCount == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    initial begin : watchdog
        wait (lineCount > 0);
        #((lineCount + 20) * 10);
        $display("ERROR: watchdog expired before all stimulus lines were run");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* rvDatapath.f */
+incdir+hw
hw/rvDatapathPkg.sv
hw/pipeStageReg.sv
hw/immExtend.sv
hw/regFile.sv
hw/aluUnit.sv
hw/executeStage.sv
hw/rvDatapath.sv
verif/rvDatapathTbClock.sv
verif/rvDatapath_properties.sv
verif/rvDatapathTb.sv

/* verif/rvDatapath_stimulus.txt */
// instr rdata immSrc aluSrc aluOp fwdA fwdB selM selW flags(regW,stF,stD,flD,flE,pcSrc)
// mask(pc,op,rdE,zero,aluM,wdM,rdW) pc opD rdE zero aluM wdM rdW group
00000013 00000000 0 0 0 0 0 0 0 00 47 00000000 13 00 0 00000000 00000000 00 1
00500093 00000000 0 0 0 0 0 0 0 00 47 00000004 13 00 0 00000000 00000000 00 1
FFD00113 00000000 0 0 0 0 0 0 0 00 47 00000008 13 00 0 00000000 00000000 00 1
002081B3 00000000 0 1 0 0 0 0 0 00 47 0000000C 13 01 0 00000000 00000000 00 1
00000013 00000000 0 1 0 0 0 0 0 00 57 00000010 33 02 0 00000005 00000000 00 2
00000013 00000000 0 0 0 1 2 0 0 20 57 00000014 13 03 0 FFFFFFFD 00000000 01 2
00108233 00000000 0 0 0 0 0 0 0 20 57 00000018 13 00 0 00000002 00000000 02 2
00302423 00000000 0 0 0 0 0 0 0 20 47 0000001C 33 00 0 00000000 00000000 03 2
00700013 00000000 1 0 0 0 0 0 0 00 47 00000020 23 04 0 00000000 00000000 00 2
00002383 00000000 0 1 0 0 0 0 0 00 57 00000024 13 08 0 0000000A 00000000 00 3
00000013 00000000 0 1 0 0 0 0 0 00 77 00000028 03 00 0 00000008 00000002 04 3
000002B3 00000000 0 1 0 0 0 0 0 00 57 0000002C 13 07 0 00000007 00000000 08 3
00038433 CAFE0001 0 0 0 0 0 0 0 20 57 00000030 33 00 0 00000000 00000000 00 3
00000013 00000000 0 0 0 0 0 0 1 20 47 00000034 33 05 0 00000000 00000000 07 3
123454B7 00000000 0 0 0 0 0 0 0 00 57 00000038 13 08 0 00000000 00000000 00 3
00148513 00000000 4 0 0 0 0 0 0 00 57 0000003C 37 00 0 CAFE0001 00000000 05 3
000005EF 00000000 0 0 0 0 0 0 0 00 47 00000040 13 09 0 00000000 00000000 08 3
00058613 00000000 3 1 0 2 0 3 0 00 57 00000044 6F 0A 0 00000002 00000000 00 4
00000013 00000000 0 0 0 0 0 0 0 00 57 00000048 13 0B 0 12345001 00000000 09 4
00000013 00000000 0 1 0 2 0 2 0 00 5F 0000004C 13 0C 0 00000000 00000000 0A 4
00000013 00000000 0 0 0 0 0 0 0 00 57 00000050 13 00 0 00000044 00000000 0B 4
000556B7 00000000 0 0 0 0 0 0 0 00 47 00000054 13 00 0 00000000 00000000 0C 5
00000013 00000000 0 0 0 0 0 0 0 1A 47 00000058 37 00 0 00000000 00000000 00 5
00055737 00000000 0 0 0 0 0 0 0 00 47 00000058 37 00 0 00000000 00000000 00 5
00000013 00000000 0 0 0 0 0 0 0 0C 47 0000005C 37 0D 0 00000000 00000000 00 5
00000013 00000000 0 0 0 0 0 0 0 00 47 00000060 13 0E 0 00000000 00000000 00 5
00000013 00000000 0 0 0 0 0 0 0 00 47 00000064 13 00 0 00000000 00000000 0D 5
00108863 00000000 0 0 0 0 0 0 0 00 47 00000068 13 00 0 00000000 00000000 0E 6
00000013 00000000 2 0 0 0 0 0 0 00 47 0000006C 63 00 0 00000000 00000000 00 6
00000013 00000000 0 0 1 0 0 0 0 07 4F 00000070 13 10 1 00000000 00000000 00 6
00000013 00000000 0 0 0 0 0 0 0 00 47 00000078 13 00 0 00000000 00000000 00 6
00000013 00000000 0 0 0 0 0 0 0 00 47 0000007C 13 00 0 00000000 00000000 10 6
00000013 00000000 0 0 0 0 0 0 0 00 47 00000080 13 00 0 00000000 00000000 00 6
